// ==== logic/mandel_pkg.sv ====
package mandel_pkg;

	////////////////////////////////////////////////////////////
	// Fixed-point formats
	////////////////////////////////////////////////////////////

	// Signed 4.23, used for c and z
	typedef logic signed [26:0] fix_t;

	// Full product of two fix_t values
	typedef logic signed [53:0] prod_t;

	// Signed 8.23 for squares and their sum
	typedef logic signed [30:0] sq_t;

	// Fraction bits of fix_t
	localparam int FRAC_BITS = 23;

	// Escape when |z|^2 is strictly above 4.0
	localparam sq_t ESCAPE_BOUND = sq_t'(4 << FRAC_BITS);

	////////////////////////////////////////////////////////////
	// Frame, count and colour types
	////////////////////////////////////////////////////////////

	// Pixel column or row
	typedef logic [9:0] coord_t;

	// Iteration count
	typedef logic [9:0] iter_t;

	// RRRGGGBB
	typedef logic [7:0] color_t;

	// Band 0 is count >= max_iter
	// Band k is count >= (max_iter >> k) for k = 1..8
	localparam int PALETTE_BANDS = 9;

	// Counts under every threshold fall back to band 8
	localparam color_t PALETTE_COLORS [PALETTE_BANDS] = '{
		8'h00,
		8'h64,
		8'h64,
		8'hA9,
		8'h65,
		8'h25,
		8'h6A,
		8'h92,
		8'h92
	};

endpackage

// ==== logic/escape_iterator.sv ====
`timescale 1ns/1ps

module escape_iterator #(
	parameter mandel_pkg::iter_t MAX_ITER = 10'd1000
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  mandel_pkg::fix_t  req_cr,
	input  mandel_pkg::fix_t  req_ci,
	output logic              req_ready,
	output logic              res_valid,
	output mandel_pkg::iter_t res_count,
	input  logic              res_ready
);
	import mandel_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STEP,
		ST_HOLD
	} state_t;

	state_t state;

	// Point under test and current z
	fix_t cr;
	fix_t ci;
	fix_t zr;
	fix_t zi;
	iter_t count;

	// Full-width products of the current z
	prod_t prod_rr;
	prod_t prod_ii;
	prod_t prod_ri;

	// Products rescaled to 4.23
	fix_t rr_fix;
	fix_t ii_fix;
	fix_t ri_fix;

	fix_t zr_next;
	fix_t zi_next;
	sq_t sum_sq;
	logic stop;

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	// zr^2, zi^2 and zr*zi from the registered z
	assign prod_rr = zr * zr;
	assign prod_ii = zi * zi;
	assign prod_ri = zr * zi;

	assign rr_fix = fix_t'(prod_rr >>> FRAC_BITS);
	assign ii_fix = fix_t'(prod_ii >>> FRAC_BITS);
	assign ri_fix = fix_t'(prod_ri >>> FRAC_BITS);

	// Magnitude in the wider format so it cannot wrap
	assign sum_sq = sq_t'(prod_rr >>> FRAC_BITS) + sq_t'(prod_ii >>> FRAC_BITS);

	// Next z, sums wrap in 4.23
	assign zr_next = rr_fix - ii_fix + cr;
	assign zi_next = (ri_fix <<< 1) + ci;

	// Squares belong to the z reached after count steps
	assign stop = (sum_sq > ESCAPE_BOUND) || (count == MAX_ITER);

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req_valid) begin
			// New point, z starts at the origin
			cr <= req_cr;
			ci <= req_ci;
			zr <= '0;
			zi <= '0;
			count <= '0;
		end else if (state == ST_STEP && !stop) begin
			zr <= zr_next;
			zi <= zi_next;
			count <= count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_valid) begin
						state <= ST_STEP;
					end
				end
				ST_STEP: begin
					// One step per cycle until escape or limit
					if (stop) begin
						state <= ST_HOLD;
					end
				end
				ST_HOLD: begin
					// Count stays put until the scanner takes it
					if (res_ready) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Handshake flags straight from the state
	assign req_ready = (state == ST_IDLE);
	assign res_valid = (state == ST_HOLD);
	assign res_count = count;

endmodule

// ==== logic/palette_lut.sv ====
`timescale 1ns/1ps

module palette_lut #(
	parameter mandel_pkg::iter_t MAX_ITER = 10'd1000
) (
	input  mandel_pkg::iter_t  count,
	output mandel_pkg::color_t color
);
	import mandel_pkg::*;

	// Thresholds halve per band
	// Walk from the last band down so the lowest matching band wins
	always_comb begin
		color = PALETTE_COLORS[PALETTE_BANDS - 1];
		for (int k = PALETTE_BANDS - 1; k >= 0; k--) begin
			if (count >= (MAX_ITER >> k)) begin
				color = PALETTE_COLORS[k];
			end
		end
	end

endmodule

// ==== logic/plane_scanner.sv ====
`timescale 1ns/1ps

module plane_scanner #(
	parameter mandel_pkg::coord_t H_PIXELS = 10'd640,
	parameter mandel_pkg::coord_t V_PIXELS = 10'd480,
	parameter mandel_pkg::iter_t  MAX_ITER = 10'd1000,
	parameter mandel_pkg::fix_t   X_START  = -27'sd16777216,
	parameter mandel_pkg::fix_t   Y_START  = 27'sd8388608,
	parameter mandel_pkg::fix_t   X_STEP   = 27'sd39321,
	parameter mandel_pkg::fix_t   Y_STEP   = 27'sd34952
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	output logic               busy,
	output logic               req_valid,
	output mandel_pkg::fix_t   req_cr,
	output mandel_pkg::fix_t   req_ci,
	input  logic               req_ready,
	input  logic               res_valid,
	input  mandel_pkg::iter_t  res_count,
	output logic               res_ready,
	output logic               pix_valid,
	output mandel_pkg::coord_t pix_x,
	output mandel_pkg::coord_t pix_y,
	output mandel_pkg::color_t pix_color,
	input  logic               pix_ready,
	output logic               frame_done
);
	import mandel_pkg::*;

	localparam coord_t H_LAST = H_PIXELS - 1'b1;
	localparam coord_t V_LAST = V_PIXELS - 1'b1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SCAN,
		ST_DRAIN
	} state_t;

	state_t state;

	// Next point to issue
	coord_t col;
	coord_t row;
	fix_t cr_run;
	fix_t ci_run;

	// Coordinates of the point inside the iterator
	coord_t fly_x;
	coord_t fly_y;

	color_t lut_color;
	logic req_take;
	logic res_take;
	logic pix_take;
	logic last_req;
	logic last_pix;

	assign req_take = req_valid & req_ready;
	assign res_take = res_valid & res_ready;
	assign pix_take = pix_valid & pix_ready;

	assign last_req = (col == H_LAST) && (row == V_LAST);
	assign last_pix = (pix_x == H_LAST) && (pix_y == V_LAST);

	// Output register free, or emptying this cycle
	assign res_ready = !pix_valid || pix_ready;

	assign req_cr = cr_run;
	assign req_ci = ci_run;
	assign busy = (state != ST_IDLE);

	palette_lut #(
		.MAX_ITER(MAX_ITER)
	) u_palette (
		.count(res_count),
		.color(lut_color)
	);

	////////////////////////////////////////////////////////////
	// Frame sequencing and handshakes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
			req_valid <= 1'b0;
			pix_valid <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					// First request goes out with the start
					if (start) begin
						state <= ST_SCAN;
						req_valid <= 1'b1;
					end
				end
				ST_SCAN: begin
					if (req_take && last_req) begin
						state <= ST_DRAIN;
					end
				end
				ST_DRAIN: begin
					// Final pixel leaves
					if (pix_take && last_pix) begin
						state <= ST_IDLE;
						frame_done <= 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase

			// Next request once the previous result is parked in the output
			if (req_take) begin
				req_valid <= 1'b0;
			end else if (res_take && state == ST_SCAN) begin
				req_valid <= 1'b1;
			end

			if (res_take) begin
				pix_valid <= 1'b1;
			end else if (pix_take) begin
				pix_valid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Coordinate stepping and pixel register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			col <= '0;
			row <= '0;
			cr_run <= X_START;
			ci_run <= Y_START;
		end else if (req_take) begin
			fly_x <= col;
			fly_y <= row;
			if (col == H_LAST) begin
				// Row wrap, back to the left edge and one row down
				col <= '0;
				row <= row + 1'b1;
				cr_run <= X_START;
				ci_run <= ci_run - Y_STEP;
			end else begin
				col <= col + 1'b1;
				cr_run <= cr_run + X_STEP;
			end
		end

		// Coloured result with its coordinates
		if (res_take) begin
			pix_x <= fly_x;
			pix_y <= fly_y;
			pix_color <= lut_color;
		end
	end

endmodule

// ==== logic/mandel_render_top.sv ====
`timescale 1ns/1ps

module mandel_render_top #(
	parameter mandel_pkg::coord_t H_PIXELS = 10'd640,
	parameter mandel_pkg::coord_t V_PIXELS = 10'd480,
	parameter mandel_pkg::iter_t  MAX_ITER = 10'd1000,
	parameter mandel_pkg::fix_t   X_START  = -27'sd16777216,
	parameter mandel_pkg::fix_t   Y_START  = 27'sd8388608,
	parameter mandel_pkg::fix_t   X_STEP   = 27'sd39321,
	parameter mandel_pkg::fix_t   Y_STEP   = 27'sd34952
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	output logic               busy,
	output logic               pix_valid,
	input  logic               pix_ready,
	output mandel_pkg::coord_t pix_x,
	output mandel_pkg::coord_t pix_y,
	output mandel_pkg::color_t pix_color,
	output logic               frame_done
);
	import mandel_pkg::*;

	// Scanner to iterator
	logic req_valid;
	logic req_ready;
	fix_t req_cr;
	fix_t req_ci;

	// Iterator to scanner
	logic res_valid;
	logic res_ready;
	iter_t res_count;

	plane_scanner #(
		.H_PIXELS(H_PIXELS),
		.V_PIXELS(V_PIXELS),
		.MAX_ITER(MAX_ITER),
		.X_START(X_START),
		.Y_START(Y_START),
		.X_STEP(X_STEP),
		.Y_STEP(Y_STEP)
	) u_scanner (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.req_valid(req_valid),
		.req_cr(req_cr),
		.req_ci(req_ci),
		.req_ready(req_ready),
		.res_valid(res_valid),
		.res_count(res_count),
		.res_ready(res_ready),
		.pix_valid(pix_valid),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_color(pix_color),
		.pix_ready(pix_ready),
		.frame_done(frame_done)
	);

	escape_iterator #(
		.MAX_ITER(MAX_ITER)
	) u_iterator (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_cr(req_cr),
		.req_ci(req_ci),
		.req_ready(req_ready),
		.res_valid(res_valid),
		.res_count(res_count),
		.res_ready(res_ready)
	);

endmodule

// ==== include/mandel_model.svh ====
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

// Escape count for one point, same step order as the iterator
function automatic mandel_pkg::iter_t model_count(input mandel_pkg::fix_t cr,
		input mandel_pkg::fix_t ci, input mandel_pkg::iter_t max_iter);
	mandel_pkg::fix_t zr;
	mandel_pkg::fix_t zi;
	mandel_pkg::prod_t prod_rr;
	mandel_pkg::prod_t prod_ii;
	mandel_pkg::prod_t prod_ri;
	mandel_pkg::fix_t ri_fix;
	mandel_pkg::sq_t sum_sq;
	mandel_pkg::iter_t count;
	zr = '0;
	zi = '0;
	count = '0;
	while (1) begin
		prod_rr = zr * zr;
		prod_ii = zi * zi;
		prod_ri = zr * zi;
		sum_sq = mandel_pkg::sq_t'(prod_rr >>> mandel_pkg::FRAC_BITS)
			+ mandel_pkg::sq_t'(prod_ii >>> mandel_pkg::FRAC_BITS);
		if (sum_sq > mandel_pkg::ESCAPE_BOUND || count == max_iter) begin
			return count;
		end
		ri_fix = mandel_pkg::fix_t'(prod_ri >>> mandel_pkg::FRAC_BITS);
		zr = mandel_pkg::fix_t'(prod_rr >>> mandel_pkg::FRAC_BITS)
			- mandel_pkg::fix_t'(prod_ii >>> mandel_pkg::FRAC_BITS) + cr;
		zi = (ri_fix <<< 1) + ci;
		count = count + 1'b1;
	end
endfunction

// Threshold bands, lowest matching band wins
function automatic mandel_pkg::color_t model_color(input mandel_pkg::iter_t count,
		input mandel_pkg::iter_t max_iter);
	for (int k = 0; k < mandel_pkg::PALETTE_BANDS; k++) begin
		if (count >= (max_iter >> k)) begin
			return mandel_pkg::PALETTE_COLORS[k];
		end
	end
	return mandel_pkg::PALETTE_COLORS[mandel_pkg::PALETTE_BANDS - 1];
endfunction

// Raster index to coordinates and c, wrapping like the running sums
function automatic void model_pixel(input int idx, input mandel_pkg::coord_t h_pixels,
		input mandel_pkg::fix_t x_start, input mandel_pkg::fix_t y_start,
		input mandel_pkg::fix_t x_step, input mandel_pkg::fix_t y_step,
		output mandel_pkg::coord_t x, output mandel_pkg::coord_t y,
		output mandel_pkg::fix_t cr, output mandel_pkg::fix_t ci);
	x = mandel_pkg::coord_t'(idx % h_pixels);
	y = mandel_pkg::coord_t'(idx / h_pixels);
	cr = mandel_pkg::fix_t'(longint'(x_start) + longint'(x) * longint'(x_step));
	ci = mandel_pkg::fix_t'(longint'(y_start) - longint'(y) * longint'(y_step));
endfunction

`endif

// ==== test/mandel_tb.sv ====
`timescale 1ns/1ps

module mandel_tb;
	import mandel_pkg::*;

	`include "mandel_model.svh"

	////////////////////////////////////////////////////////////
	// Frame setup
	////////////////////////////////////////////////////////////

	localparam coord_t H_PIXELS = 10'd16;
	localparam coord_t V_PIXELS = 10'd12;
	localparam iter_t MAX_ITER = 10'd64;
	// -2.0, 1.0, 3/16 and 2/12 in 4.23
	localparam fix_t X_START = -27'sd16777216;
	localparam fix_t Y_START = 27'sd8388608;
	localparam fix_t X_STEP = 27'sd1572864;
	localparam fix_t Y_STEP = 27'sd1398101;

	localparam int NUM_PIX = H_PIXELS * V_PIXELS;
	localparam int TIMEOUT_CYCLES = 2 * NUM_PIX * (MAX_ITER + 4) * 4;
	localparam int SEED = 32'hf70c9b38;

	// Test ids
	localparam int T_RASTER = 0;
	localparam int T_COLOR = 1;
	localparam int T_BP = 2;
	localparam int T_DONE = 3;
	localparam int T_RESTART = 4;
	localparam int T_RESET = 5;
	localparam int NUM_TESTS = 6;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic busy;
	logic pix_valid;
	logic pix_ready;
	coord_t pix_x;
	coord_t pix_y;
	color_t pix_color;
	logic frame_done;

	// Expected frame from the model
	coord_t exp_x [NUM_PIX];
	coord_t exp_y [NUM_PIX];
	color_t exp_color [NUM_PIX];
	color_t first_color [NUM_PIX];

	int check_count [NUM_TESTS];
	int err_count [NUM_TESTS];
	int frame_pixels [3];
	int cycles = 0;

	// Monitor state
	logic in_frame = 1'b0;
	int frame_no = 0;
	int pix_idx = 0;
	int stall_cycles = 0;
	logic last_xfer = 1'b0;
	logic prev_done = 1'b0;
	logic prev_valid = 1'b0;
	logic prev_ready = 1'b0;
	coord_t prev_x;
	coord_t prev_y;
	color_t prev_color;

	mandel_render_top #(
		.H_PIXELS(H_PIXELS),
		.V_PIXELS(V_PIXELS),
		.MAX_ITER(MAX_ITER),
		.X_START(X_START),
		.Y_START(Y_START),
		.X_STEP(X_STEP),
		.Y_STEP(Y_STEP)
	) dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_color(pix_color),
		.frame_done(frame_done)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Check and report helpers
	////////////////////////////////////////////////////////////

	function automatic string test_label(input int id);
		case (id)
			T_RASTER: return "raster order";
			T_COLOR: return "colour";
			T_BP: return "back-pressure";
			T_DONE: return "frame completion";
			T_RESTART: return "restart and idle start";
			default: return "reset";
		endcase
	endfunction

	task automatic check_value(input int id, input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count[id]++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %0h, expected %0h (t=%0t)", name, got, exp, $time);
			err_count[id]++;
		end
	endtask

	task automatic check_true(input int id, input logic cond, input string what);
		check_count[id]++;
		assert (cond === 1'b1) else begin
			$display("Error in %s test at t=%0t: %s", test_label(id), $time, what);
			err_count[id]++;
		end
	endtask

	task automatic report_test(input int id);
		$display("Test %-24s %s (%0d checks, %0d errors)", test_label(id),
			(err_count[id] == 0) ? "passed" : "failed", check_count[id], err_count[id]);
	endtask

	function automatic int total_errors();
		int sum;
		sum = 0;
		for (int k = 0; k < NUM_TESTS; k++) begin
			sum += err_count[k];
		end
		return sum;
	endfunction

	task automatic print_summary();
		int checks;
		int passed;
		checks = 0;
		passed = 0;
		for (int k = 0; k < NUM_TESTS; k++) begin
			checks += check_count[k];
			if (err_count[k] == 0) begin
				passed++;
			end
		end
		$display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
			passed, NUM_TESTS, checks, total_errors());
	endtask

	// Coordinates and colour of every raster index
	task automatic build_expected();
		coord_t x;
		coord_t y;
		fix_t cr;
		fix_t ci;
		iter_t cnt;
		int black;
		int low;
		black = 0;
		low = 0;
		for (int i = 0; i < NUM_PIX; i++) begin
			model_pixel(i, H_PIXELS, X_START, Y_START, X_STEP, Y_STEP, x, y, cr, ci);
			cnt = model_count(cr, ci, MAX_ITER);
			exp_x[i] = x;
			exp_y[i] = y;
			exp_color[i] = model_color(cnt, MAX_ITER);
			if (cnt == MAX_ITER) begin
				black++;
			end
			if (cnt < (MAX_ITER >> 3)) begin
				low++;
			end
		end
		// Frame should reach both ends of the palette
		check_true(T_COLOR, (black > 0) && (low > 0), "frame lacks black or low-band pixels");
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_frame_done();
		@(posedge clk);
		while (frame_done !== 1'b1) begin
			@(posedge clk);
		end
		// One more edge so the monitor has booked the frame
		@(posedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Sink that stalls at random and is ready about 70 % of the time
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		forever begin
			@(posedge clk);
			if (rst) begin
				pix_ready <= 1'b0;
			end else begin
				pix_ready <= (($urandom % 100) < 70);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stream monitor
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		logic xfer;
		xfer = 1'b0;
		if (!rst) begin
			// Stalled beat must hold still
			if (prev_valid && !prev_ready) begin
				stall_cycles++;
				check_true(T_BP, pix_valid, "pix_valid dropped during a stall");
				check_value(T_BP, "pix_x", pix_x, prev_x);
				check_value(T_BP, "pix_y", pix_y, prev_y);
				check_value(T_BP, "pix_color", pix_color, prev_color);
			end
			if (pix_valid && !in_frame) begin
				check_true(T_DONE, 1'b0, "pix_valid high with no frame running");
			end
			if (pix_valid && pix_ready && in_frame) begin
				xfer = 1'b1;
				if (pix_idx >= NUM_PIX) begin
					check_true(T_RASTER, 1'b0, "more pixels than the frame holds");
				end else begin
					check_value(T_RASTER, "pix_x", pix_x, exp_x[pix_idx]);
					check_value(T_RASTER, "pix_y", pix_y, exp_y[pix_idx]);
					check_value(T_COLOR, "pix_color", pix_color, exp_color[pix_idx]);
					if (frame_no == 1) begin
						first_color[pix_idx] = pix_color;
					end else begin
						check_value(T_RESTART, "pix_color", pix_color, first_color[pix_idx]);
					end
				end
				pix_idx++;
			end
			// Done pulse right after the final beat
			if (frame_done) begin
				check_true(T_DONE, last_xfer, "frame_done without a final transfer before it");
				check_true(T_DONE, !prev_done, "frame_done high for more than one cycle");
				check_value(T_DONE, "busy", busy, 32'h0);
				if (in_frame) begin
					frame_pixels[frame_no] = pix_idx;
				end
				in_frame = 1'b0;
			end else if (last_xfer) begin
				check_true(T_DONE, 1'b0, "frame_done missing after the last pixel");
			end
			last_xfer = xfer && (pix_idx == NUM_PIX);
			prev_done = frame_done;
			// Start is only taken while idle
			if (start && !busy) begin
				in_frame = 1'b1;
				pix_idx = 0;
				frame_no++;
			end
			prev_valid = pix_valid;
			prev_ready = pix_ready;
			prev_x = pix_x;
			prev_y = pix_y;
			prev_color = pix_color;
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: no finish within %0d cycles", TIMEOUT_CYCLES);
			print_summary();
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		start = 1'b0;
		pix_ready = 1'b0;
		build_expected();
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// Quiet outputs before any start
		repeat (4) begin
			@(posedge clk);
			check_value(T_RESET, "busy", busy, 32'h0);
			check_value(T_RESET, "pix_valid", pix_valid, 32'h0);
			check_value(T_RESET, "frame_done", frame_done, 32'h0);
		end
		report_test(T_RESET);

		// First frame
		pulse_start();
		wait_frame_done();
		check_value(T_RASTER, "frame 1 pixel count", frame_pixels[1], NUM_PIX);
		check_true(T_BP, stall_cycles > 0, "the sink never stalled the stream");

		// Second frame with a start while busy
		pulse_start();
		repeat (40) @(posedge clk);
		check_value(T_RESTART, "busy", busy, 32'h1);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		wait_frame_done();
		check_value(T_RESTART, "frame 2 pixel count", frame_pixels[2], NUM_PIX);

		// Nothing more after the done pulse
		repeat (30) begin
			@(posedge clk);
			check_value(T_DONE, "busy", busy, 32'h0);
		end
		check_value(T_RESTART, "frames started", frame_no, 32'd2);

		report_test(T_RASTER);
		report_test(T_COLOR);
		report_test(T_BP);
		report_test(T_DONE);
		report_test(T_RESTART);
		print_summary();
		if (total_errors() == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
logic/mandel_pkg.sv
logic/escape_iterator.sv
logic/palette_lut.sv
logic/plane_scanner.sv
logic/mandel_render_top.sv
test/mandel_tb.sv
